// ==== files.f ====
icache_pkg.sv
icache_bus_pkg.sv
icache_array.sv
icache_refill_ctrl.sv
icache_csr.sv
icache_top.sv
tb_icache.sv

// ==== icache_array.sv ====
// Direct-mapped line store with tags, valid bits, registered lookup and whole-line fill
`timescale 1ns/1ps
`default_nettype none

module icache_array (
	input wire iCLOCK,
	input wire inRESET,
	input wire flush,
	input wire lookup_req,
	input wire [31:0] lookup_addr,
	input wire hold,
	output logic lookup_valid,
	output logic lookup_hit,
	output icache_pkg::beat_t lookup_beat,
	input wire fill_req,
	input wire [31:0] fill_addr,
	input wire icache_pkg::line_t fill_line
);

	// Storage
	logic [icache_pkg::TAG_W-1:0] tag_mem [icache_pkg::LINE_COUNT];
	icache_pkg::line_t line_mem [icache_pkg::LINE_COUNT];
	logic [icache_pkg::LINE_COUNT-1:0] line_valid;

	// Lookup and fill address fields
	logic [icache_pkg::TAG_W-1:0] rd_tag;
	logic [icache_pkg::INDEX_W-1:0] rd_index;
	logic [icache_pkg::OFFSET_W-4:0] rd_beat;
	logic [icache_pkg::INDEX_W-1:0] wr_index;
	logic rd_match;

	assign rd_tag = lookup_addr[31 -: icache_pkg::TAG_W];
	assign rd_index = lookup_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
	assign rd_beat = lookup_addr[icache_pkg::OFFSET_W-1:3];
	assign wr_index = fill_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];

	// Single way, so one tag compare decides the hit
	assign rd_match = line_valid[rd_index] && (tag_mem[rd_index] == rd_tag);

	// Lookup result flags, frozen while the consumer stalls
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			lookup_valid <= 1'b0;
			lookup_hit <= 1'b0;
		end else if (!hold) begin
			lookup_valid <= lookup_req;
			lookup_hit <= lookup_req && rd_match;
		end
	end

	// Addressed beat of the indexed line
	always_ff @(posedge iCLOCK) begin
		if (!hold && lookup_req) begin
			lookup_beat <= line_mem[rd_index][rd_beat*icache_pkg::BEAT_W +: icache_pkg::BEAT_W];
		end
	end

	// Valid bits, flush wins over a fill on the same edge
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			line_valid <= '0;
		end else if (flush) begin
			line_valid <= '0;
		end else if (fill_req) begin
			line_valid[wr_index] <= 1'b1;
		end
	end

	// Tag and line write
	always_ff @(posedge iCLOCK) begin
		if (fill_req) begin
			tag_mem[wr_index] <= fill_addr[31 -: icache_pkg::TAG_W];
			line_mem[wr_index] <= fill_line;
		end
	end

endmodule

`default_nettype wire

// ==== icache_bus_pkg.sv ====
// Wishbone register map and data type of the cache configuration port
`default_nettype none

package icache_bus_pkg;

	// Word address width of the register port
	localparam int WB_ADDR_W = 2;

	typedef logic [31:0] reg_data_t;

	// Register map
	typedef enum logic [WB_ADDR_W-1:0] {
		REG_CTRL = 2'd0,
		REG_HITS = 2'd1,
		REG_MISSES = 2'd2,
		REG_STATUS = 2'd3
	} csr_addr_e;

endpackage

`default_nettype wire

// ==== icache_csr.sv ====
// Wishbone classic register block for cache enable, flush and hit/miss counters
`timescale 1ns/1ps
`default_nettype none

module icache_csr (
	input wire iCLOCK,
	input wire inRESET,
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [icache_bus_pkg::WB_ADDR_W-1:0] wb_adr,
	input wire icache_bus_pkg::reg_data_t wb_dat_w,
	output icache_bus_pkg::reg_data_t wb_dat_r,
	output logic wb_ack,
	input wire hit_pulse,
	input wire miss_pulse,
	input wire busy,
	output logic cache_enable,
	output logic flush_pulse
);

	icache_bus_pkg::reg_data_t hit_cnt;
	icache_bus_pkg::reg_data_t miss_cnt;
	icache_bus_pkg::csr_addr_e reg_sel;
	logic access;
	logic wr_ctrl;
	logic wr_hits;
	logic wr_misses;

	assign reg_sel = icache_bus_pkg::csr_addr_e'(wb_adr);

	// One access per cycle, ack blocks a second one
	assign access = wb_cyc && wb_stb && !wb_ack;
	assign wr_ctrl = access && wb_we && (reg_sel == icache_bus_pkg::REG_CTRL);
	assign wr_hits = access && wb_we && (reg_sel == icache_bus_pkg::REG_HITS);
	assign wr_misses = access && wb_we && (reg_sel == icache_bus_pkg::REG_MISSES);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wb_ack <= 1'b0;
			cache_enable <= 1'b1;
			flush_pulse <= 1'b0;
		end else begin
			wb_ack <= access;
			flush_pulse <= wr_ctrl && wb_dat_w[1];
			if (wr_ctrl) begin
				cache_enable <= wb_dat_w[0];
			end
		end
	end

	// Saturating counters, cleared by any write
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			hit_cnt <= '0;
			miss_cnt <= '0;
		end else begin
			if (wr_hits) begin
				hit_cnt <= '0;
			end else if (hit_pulse && (hit_cnt != '1)) begin
				hit_cnt <= hit_cnt + 1'b1;
			end
			if (wr_misses) begin
				miss_cnt <= '0;
			end else if (miss_pulse && (miss_cnt != '1)) begin
				miss_cnt <= miss_cnt + 1'b1;
			end
		end
	end

	// Read data lands together with ack
	always_ff @(posedge iCLOCK) begin
		if (access && !wb_we) begin
			case (reg_sel)
				icache_bus_pkg::REG_CTRL: wb_dat_r <= icache_bus_pkg::reg_data_t'(cache_enable);
				icache_bus_pkg::REG_HITS: wb_dat_r <= hit_cnt;
				icache_bus_pkg::REG_MISSES: wb_dat_r <= miss_cnt;
				icache_bus_pkg::REG_STATUS: wb_dat_r <= icache_bus_pkg::reg_data_t'(busy);
				default: wb_dat_r <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
// Instruction cache geometry, storage types and controller state encoding
`default_nettype none

package icache_pkg;

	// Data widths
	localparam int INST_W = 32;
	localparam int BEAT_W = 64;

	// Line organisation, 16 lines of 64 bytes
	localparam int LINE_BEATS = 8;
	localparam int LINE_COUNT = 16;

	// Address split
	localparam int OFFSET_W = 6;
	localparam int INDEX_W = 4;
	localparam int TAG_W = 22;

	typedef logic [INST_W-1:0] inst_t;
	typedef logic [BEAT_W-1:0] beat_t;
	typedef logic [BEAT_W*LINE_BEATS-1:0] line_t;

	// Refill controller states
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_MEMREQ = 2'd1,
		ST_MEMGET = 2'd2,
		ST_OUTINST = 2'd3
	} ctrl_state_e;

endpackage

`default_nettype wire

// ==== icache_refill_ctrl.sv ====
// Instruction cache controller with hit path, miss refill FSM and fetch output select
`timescale 1ns/1ps
`default_nettype none

module icache_refill_ctrl (
	input wire iCLOCK,
	input wire inRESET,
	// Fetch unit
	input wire fetch_req,
	input wire [31:0] fetch_addr,
	output logic fetch_lock,
	output logic inst0_valid,
	output icache_pkg::inst_t inst0,
	output logic inst1_valid,
	output icache_pkg::inst_t inst1,
	input wire next_lock,
	// Memory
	output logic mem_req,
	output logic [31:0] mem_addr,
	input wire mem_lock,
	input wire mem_valid,
	input wire icache_pkg::beat_t mem_data,
	// Configuration block
	input wire cache_enable,
	output logic hit_pulse,
	output logic miss_pulse,
	output logic busy,
	// Line array
	output logic lookup_req,
	output logic [31:0] lookup_addr,
	input wire lookup_valid,
	input wire lookup_hit,
	input wire icache_pkg::beat_t lookup_beat,
	output logic fill_req,
	output logic [31:0] fill_addr,
	output icache_pkg::line_t fill_line
);

	icache_pkg::ctrl_state_e state;
	logic [icache_pkg::OFFSET_W-4:0] req_cnt;
	logic [icache_pkg::OFFSET_W-4:0] get_cnt;
	logic [31:0] req_addr;
	logic line_mode;
	icache_pkg::beat_t crit_beat;
	icache_pkg::line_t line_buf;

	logic hit_eff;
	logic miss_seen;
	logic beat_in;
	logic req_last;
	logic get_last;
	logic get_crit;
	logic out_valid;
	icache_pkg::beat_t out_beat;

	// A disabled cache treats every lookup as a miss
	assign hit_eff = lookup_hit && cache_enable;
	assign miss_seen = lookup_valid && !hit_eff;

	assign busy = (state != icache_pkg::ST_IDLE);
	assign fetch_lock = busy || next_lock || miss_seen;
	assign lookup_req = fetch_req && !fetch_lock;
	assign lookup_addr = {fetch_addr[31:3], 3'b000};

	// Statistics count when the result is consumed
	assign hit_pulse = lookup_valid && hit_eff && !next_lock;
	assign miss_pulse = miss_seen && !next_lock;

	// A line miss walks all beats and a bypass miss only one
	assign beat_in = mem_valid &&
		((state == icache_pkg::ST_MEMREQ) || (state == icache_pkg::ST_MEMGET));
	assign req_last = !line_mode ||
		(req_cnt == (icache_pkg::OFFSET_W-3)'(icache_pkg::LINE_BEATS - 1));
	assign get_last = !line_mode ||
		(get_cnt == (icache_pkg::OFFSET_W-3)'(icache_pkg::LINE_BEATS - 1));
	assign get_crit = !line_mode || (get_cnt == req_addr[icache_pkg::OFFSET_W-1:3]);

	assign mem_req = (state == icache_pkg::ST_MEMREQ);
	assign mem_addr = line_mode ?
		{req_addr[31:icache_pkg::OFFSET_W], req_cnt, 3'b000} : {req_addr[31:3], 3'b000};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= icache_pkg::ST_IDLE;
			req_cnt <= '0;
			get_cnt <= '0;
			req_addr <= '0;
			line_mode <= 1'b0;
		end else begin
			if (lookup_req) begin
				req_addr <= fetch_addr;
			end
			if (beat_in) begin
				get_cnt <= get_cnt + 1'b1;
			end
			case (state)
				icache_pkg::ST_IDLE: begin
					if (miss_seen && !next_lock) begin
						state <= icache_pkg::ST_MEMREQ;
						req_cnt <= '0;
						get_cnt <= '0;
						// Mode is fixed for the whole miss
						line_mode <= cache_enable;
					end
				end
				icache_pkg::ST_MEMREQ: begin
					if (!mem_lock) begin
						if (req_last) begin
							state <= icache_pkg::ST_MEMGET;
						end else begin
							req_cnt <= req_cnt + 1'b1;
						end
					end
				end
				icache_pkg::ST_MEMGET: begin
					if (beat_in && get_last) begin
						state <= icache_pkg::ST_OUTINST;
					end
				end
				icache_pkg::ST_OUTINST: begin
					if (!next_lock) begin
						state <= icache_pkg::ST_IDLE;
					end
				end
				default: begin
					state <= icache_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// First beat of the line ends up in the low bits
	always_ff @(posedge iCLOCK) begin
		if (beat_in) begin
			line_buf <= {mem_data,
				line_buf[icache_pkg::LINE_BEATS*icache_pkg::BEAT_W-1:icache_pkg::BEAT_W]};
			if (get_crit) begin
				crit_beat <= mem_data;
			end
		end
	end

	// Line is written as the critical pair leaves
	assign fill_req = (state == icache_pkg::ST_OUTINST) && !next_lock && line_mode;
	assign fill_addr = {req_addr[31:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}};
	assign fill_line = line_buf;

	// Output pair comes from the array on a hit and from the captured beat after a miss
	assign out_valid = (state == icache_pkg::ST_OUTINST) || (lookup_valid && hit_eff);
	assign out_beat = (state == icache_pkg::ST_OUTINST) ? crit_beat : lookup_beat;

	assign inst0_valid = out_valid && !next_lock;
	assign inst1_valid = out_valid && !req_addr[2] && !next_lock;
	assign inst0 = req_addr[2] ?
		out_beat[icache_pkg::INST_W +: icache_pkg::INST_W] : out_beat[0 +: icache_pkg::INST_W];
	assign inst1 = out_beat[icache_pkg::INST_W +: icache_pkg::INST_W];

endmodule

`default_nettype wire

// ==== icache_stim.txt ====
// Columns op_flags_0000_addr_data0_data1; op 01 write, 02 read, 03 fetch
// Fetch flags bit0 random next_lock, bit1 inst1 valid; data0 and data1 are inst0 and inst1
// Register ops put the register index in addr and the write or expected read value in data0
03_02_0000_00001000_A5A50400_A5A50401
03_02_0000_00001008_A5A50402_A5A50403
03_00_0000_0000100C_A5A50403_00000000
02_00_0000_00000001_00000002_00000000
02_00_0000_00000002_00000001_00000000
03_00_0000_00002034_A5A5080D_00000000
03_02_0000_00001010_A5A50404_A5A50405
02_00_0000_00000002_00000003_00000000
01_00_0000_00000000_00000003_00000000
02_00_0000_00000000_00000001_00000000
03_02_0000_00001018_A5A50406_A5A50407
02_00_0000_00000002_00000004_00000000
02_00_0000_00000001_00000002_00000000
01_00_0000_00000000_00000000_00000000
03_02_0000_00001018_A5A50406_A5A50407
03_00_0000_0000101C_A5A50407_00000000
02_00_0000_00000002_00000006_00000000
02_00_0000_00000001_00000002_00000000
02_00_0000_00000000_00000000_00000000
01_00_0000_00000000_00000001_00000000
03_03_0000_00003000_A5A50C00_A5A50C01
03_03_0000_00003008_A5A50C02_A5A50C03
03_01_0000_00003004_A5A50C01_00000000
02_00_0000_00000001_00000004_00000000
02_00_0000_00000002_00000007_00000000
01_00_0000_00000001_00000000_00000000
02_00_0000_00000001_00000000_00000000
02_00_0000_00000003_00000000_00000000

// ==== icache_top.sv ====
// L1 instruction cache top joining the controller, line array and register block
`timescale 1ns/1ps
`default_nettype none

module icache_top (
	input wire iCLOCK,
	input wire inRESET,
	// Fetch unit
	input wire fetch_req,
	input wire [31:0] fetch_addr,
	output wire fetch_lock,
	output wire inst0_valid,
	output wire icache_pkg::inst_t inst0,
	output wire inst1_valid,
	output wire icache_pkg::inst_t inst1,
	input wire next_lock,
	// Memory
	output wire mem_req,
	output wire [31:0] mem_addr,
	input wire mem_lock,
	input wire mem_valid,
	input wire icache_pkg::beat_t mem_data,
	// Host register port
	input wire wb_cyc,
	input wire wb_stb,
	input wire wb_we,
	input wire [icache_bus_pkg::WB_ADDR_W-1:0] wb_adr,
	input wire icache_bus_pkg::reg_data_t wb_dat_w,
	output wire icache_bus_pkg::reg_data_t wb_dat_r,
	output wire wb_ack
);

	// Controller to register block
	logic cache_enable;
	logic flush_pulse;
	logic hit_pulse;
	logic miss_pulse;
	logic busy;

	// Controller to array
	logic lookup_req;
	logic [31:0] lookup_addr;
	logic lookup_valid;
	logic lookup_hit;
	icache_pkg::beat_t lookup_beat;
	logic fill_req;
	logic [31:0] fill_addr;
	icache_pkg::line_t fill_line;

	icache_refill_ctrl u_ctrl (.*);

	// Array stalls together with the fetch unit
	icache_array u_array (
		.*,
		.flush(flush_pulse),
		.hold(next_lock)
	);

	icache_csr u_csr (.*);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_icache \
	-f files.f -Mdir obj_dir -o sim_icache > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$build_log"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_icache > "$sim_log" 2>&1
status=$?
cat "$sim_log"

grep -q "ERRORS FOUND" "$sim_log"
grep_status=$?
if [ $grep_status -eq 0 ]; then
	echo "Simulation reported failures"
	exit 1
elif [ $grep_status -ne 1 ]; then
	echo "Could not search $sim_log"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi
echo "Simulation passed"

// ==== tb_icache.sv ====
// Testbench for the L1 instruction cache, driven by operations from a stimulus file
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

	localparam int TIMEOUT = 200;
	localparam int STIM_DEPTH = 64;

	typedef enum logic [7:0] {
		OP_END = 8'h00,
		OP_WRITE = 8'h01,
		OP_READ = 8'h02,
		OP_FETCH = 8'h03
	} stim_op_e;

	logic iCLOCK = 1'b0;
	logic inRESET;
	logic fetch_req;
	logic [31:0] fetch_addr;
	wire fetch_lock;
	wire inst0_valid;
	wire icache_pkg::inst_t inst0;
	wire inst1_valid;
	wire icache_pkg::inst_t inst1;
	logic next_lock = 1'b0;
	wire mem_req;
	wire [31:0] mem_addr;
	logic mem_lock = 1'b0;
	logic mem_valid = 1'b0;
	icache_pkg::beat_t mem_data = '0;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [icache_bus_pkg::WB_ADDR_W-1:0] wb_adr;
	icache_bus_pkg::reg_data_t wb_dat_w;
	wire icache_bus_pkg::reg_data_t wb_dat_r;
	wire wb_ack;

	// Memory model state
	int seed = 75;
	int cycle_cnt = 0;
	logic [31:0] pend_addr [$];
	int pend_due [$];
	bit lock_mode;
	logic [127:0] stim_mem [STIM_DEPTH];

	icache_top DUT (.*);

	always #4 iCLOCK = ~iCLOCK;

	task automatic abort_run();
		$display("ERRORS FOUND");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out at %0d ns while waiting for %s", $time, what);
		abort_run();
	endtask

	task automatic check_inst(input string what, input icache_pkg::inst_t got,
		input icache_pkg::inst_t exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_valid(input string what, input bit got, input bit exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_reg(input string what, input icache_bus_pkg::reg_data_t got,
		input icache_bus_pkg::reg_data_t exp);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// Instruction stored at a byte address
	function automatic icache_pkg::inst_t word_at(input logic [31:0] byte_addr);
		return (byte_addr >> 2) ^ 32'hA5A5_0000;
	endfunction

	function automatic icache_pkg::beat_t beat_at(input logic [31:0] byte_addr);
		return {word_at(byte_addr + 32'd4), word_at(byte_addr)};
	endfunction

	// Memory with random lock and latency plus random next_lock stalls
	always @(posedge iCLOCK) begin
		if (!inRESET) begin
			next_lock <= 1'b0;
			mem_lock <= 1'b0;
			mem_valid <= 1'b0;
			pend_addr.delete();
			pend_due.delete();
		end else begin
			cycle_cnt <= cycle_cnt + 1;
			next_lock <= lock_mode && (($random(seed) & 1) != 0);
			mem_lock <= (($random(seed) & 3) == 0);
			if (mem_req && !mem_lock) begin
				check_valid("mem_addr 8-byte aligned", mem_addr[2:0] == 3'b000, 1'b1);
				pend_addr.push_back(mem_addr);
				pend_due.push_back(cycle_cnt + 1 + ($random(seed) & 3));
			end
			// Beats leave in request order
			if (pend_addr.size() != 0 && pend_due[0] <= cycle_cnt) begin
				mem_valid <= 1'b1;
				mem_data <= beat_at(pend_addr.pop_front());
				void'(pend_due.pop_front());
			end else begin
				mem_valid <= 1'b0;
			end
		end
	end

	task automatic wb_transfer(input bit we, input logic [icache_bus_pkg::WB_ADDR_W-1:0] adr,
		input icache_bus_pkg::reg_data_t wdata, output icache_bus_pkg::reg_data_t rdata);
		int waited;
		@(posedge iCLOCK);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= adr;
		wb_dat_w <= wdata;
		waited = 0;
		@(negedge iCLOCK);
		while (!wb_ack) begin
			waited++;
			if (waited > TIMEOUT) report_timeout("wb_ack");
			@(negedge iCLOCK);
		end
		check_valid("wb_ack one cycle after strobe", waited == 1, 1'b1);
		rdata = wb_dat_r;
		@(posedge iCLOCK);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic run_fetch(input logic [31:0] addr, input bit lock_en, input bit exp_v1,
		input icache_pkg::inst_t exp0, input icache_pkg::inst_t exp1);
		int waited;
		@(negedge iCLOCK);
		lock_mode = lock_en;
		@(posedge iCLOCK);
		fetch_req <= 1'b1;
		fetch_addr <= addr;
		waited = 0;
		@(negedge iCLOCK);
		while (fetch_lock) begin
			waited++;
			if (waited > TIMEOUT) report_timeout("fetch request to be taken");
			@(negedge iCLOCK);
		end
		@(posedge iCLOCK);
		fetch_req <= 1'b0;
		waited = 0;
		@(negedge iCLOCK);
		while (!inst0_valid) begin
			waited++;
			if (waited > TIMEOUT) report_timeout("fetch result");
			@(negedge iCLOCK);
		end
		check_inst("inst0", inst0, exp0);
		check_valid("inst1_valid", inst1_valid, exp_v1);
		if (exp_v1) begin
			check_inst("inst1", inst1, exp1);
		end
		// Result is taken on this edge and must not show up again
		@(posedge iCLOCK);
		@(negedge iCLOCK);
		lock_mode = 1'b0;
		@(negedge iCLOCK);
		check_valid("inst0_valid after the result was taken", inst0_valid, 1'b0);
		// Idle controller with no stall accepts the next request
		check_valid("fetch_lock when idle", fetch_lock, 1'b0);
	endtask

	initial begin
		int i;
		logic [127:0] entry;
		icache_bus_pkg::reg_data_t rdata;
		inRESET = 1'b0;
		fetch_req = 1'b0;
		fetch_addr = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		lock_mode = 1'b0;
		for (i = 0; i < STIM_DEPTH; i++) begin
			stim_mem[i] = '0;
		end
		$readmemh("icache_stim.txt", stim_mem);
		repeat (8) @(posedge iCLOCK);
		inRESET <= 1'b1;
		i = 0;
		while (i < STIM_DEPTH && stim_op_e'(stim_mem[i][127:120]) != OP_END) begin
			entry = stim_mem[i];
			case (stim_op_e'(entry[127:120]))
				OP_WRITE: wb_transfer(1'b1, entry[65:64], entry[63:32], rdata);
				OP_READ: begin
					wb_transfer(1'b0, entry[65:64], '0, rdata);
					check_reg($sformatf("register %0d", entry[65:64]), rdata, entry[63:32]);
				end
				OP_FETCH: run_fetch(entry[95:64], entry[112], entry[113], entry[63:32],
					entry[31:0]);
				default: begin
					$display("Unknown operation %h on stimulus entry %0d", entry[127:120], i);
					abort_run();
				end
			endcase
			i++;
		end
		if (i == 0) begin
			$display("The stimulus file held no operations");
			abort_run();
		end else begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

`default_nettype wire
